/* include/pipe_params.svh */
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Datapath sizes
`define WORD_WIDTH     64
`define INST_WIDTH     32
`define REG_COUNT      32
`define REG_IDX_WIDTH  5
`define ZERO_REG       5'd31
`define COUNT_WIDTH    16

`define HALT_INST      32'h0000_0555

// Operate format opcodes
`define OP_INTA        6'h10
`define OP_INTL        6'h11
`define OP_SHIFT       6'h12

// Function codes, meaning depends on opcode
`define FN_ADDQ        7'h20
`define FN_SUBQ        7'h29
`define FN_CMPEQ       7'h2d
`define FN_CMPULT      7'h1d
`define FN_AND         7'h00
`define FN_BIS         7'h20
`define FN_XOR         7'h40
`define FN_SLL         7'h39
`define FN_SRL         7'h34

`define STATUS_NO_ERROR 4'h0
`define STATUS_HALTED   4'h1

`endif

/* logic/pipe_pkg.sv */
`default_nettype none

`include "pipe_params.svh"

package pipe_pkg;

  typedef logic [`WORD_WIDTH-1:0]    word_t;
  typedef logic [`INST_WIDTH-1:0]    inst_t;
  typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;
  typedef logic [3:0]                alu_op_t;
  typedef logic [3:0]                status_t;
  typedef logic [`COUNT_WIDTH-1:0]   count_t;

  // Internal ALU operations picked by decode
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_CMPEQ  = 4'd2;
  localparam alu_op_t ALU_CMPULT = 4'd3;
  localparam alu_op_t ALU_AND    = 4'd4;
  localparam alu_op_t ALU_BIS    = 4'd5;
  localparam alu_op_t ALU_XOR    = 4'd6;
  localparam alu_op_t ALU_SLL    = 4'd7;
  localparam alu_op_t ALU_SRL    = 4'd8;

  typedef enum logic {
    RUN,
    HALTED
  } decode_state_e;

endpackage

`default_nettype wire

/* logic/issue_if.sv */
`default_nettype none

// Decoded instruction from decode to execute, ALU value comes back
interface issue_if import pipe_pkg::*; ();

  logic     valid;
  inst_t    ir;
  alu_op_t  alu_op;
  word_t    opa;
  word_t    opb;
  reg_idx_t dest;
  logic     wr;
  logic     halt;
  word_t    alu_value; // Combinational, for forwarding

  modport decode (
    output valid, ir, alu_op, opa, opb, dest, wr, halt,
    input  alu_value
  );

  modport execute (
    input  valid, ir, alu_op, opa, opb, dest, wr, halt,
    output alu_value
  );

endinterface

`default_nettype wire

/* logic/result_if.sv */
`default_nettype none

// Executed instruction on its way to commit
interface result_if import pipe_pkg::*; ();

  logic     valid;
  inst_t    ir;
  reg_idx_t dest;
  word_t    value;
  logic     wr;
  logic     halt;

  modport source (
    output valid, ir, dest, value, wr, halt
  );

  modport sink (
    input valid, ir, dest, value, wr, halt
  );

endinterface

`default_nettype wire

/* logic/decode_stage.sv */
`default_nettype none

`include "pipe_params.svh"

module decode_stage import pipe_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  input  logic     inst_valid,
  input  inst_t    inst,
  output logic     inst_ready,
  output reg_idx_t rd_a_idx,
  output reg_idx_t rd_b_idx,
  input  word_t    rd_a_data,
  input  word_t    rd_b_data,
  issue_if.decode  issue
);

  decode_state_e state;
  logic          accept;
  logic          dec_valid;
  inst_t         dec_ir;
  logic [5:0]    opcode;
  logic [6:0]    func;
  reg_idx_t      ra;
  reg_idx_t      rb;
  reg_idx_t      rc;
  logic          use_lit;
  alu_op_t       alu_op;
  logic          legal;
  logic          is_halt;
  word_t         opa;
  word_t         fwd_b;
  word_t         opb;

  //////////////////////////////////////////////////
  // Input handshake and decode register

  assign inst_ready = (state == RUN);
  assign accept     = inst_valid && inst_ready;

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= RUN;
      dec_valid <= 1'b0;
    end
    else
    begin
      dec_valid <= accept;
      if (accept && inst == `HALT_INST)
        state <= HALTED; // Stays here until reset
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept)
      dec_ir <= inst;
  end

  //////////////////////////////////////////////////
  // Field decode

  assign opcode   = dec_ir[31:26];
  assign ra       = dec_ir[25:21];
  assign rb       = dec_ir[20:16];
  assign use_lit  = dec_ir[12];
  assign func     = dec_ir[11:5];
  assign rc       = dec_ir[4:0];
  assign is_halt  = (dec_ir == `HALT_INST);
  assign rd_a_idx = ra;
  assign rd_b_idx = rb;

  always_comb
  begin
    legal  = 1'b1;
    alu_op = ALU_ADD;
    case (opcode)
      `OP_INTA:
        case (func)
          `FN_ADDQ:   alu_op = ALU_ADD;
          `FN_SUBQ:   alu_op = ALU_SUB;
          `FN_CMPEQ:  alu_op = ALU_CMPEQ;
          `FN_CMPULT: alu_op = ALU_CMPULT;
          default:    legal  = 1'b0;
        endcase
      `OP_INTL:
        case (func)
          `FN_AND:  alu_op = ALU_AND;
          `FN_BIS:  alu_op = ALU_BIS;
          `FN_XOR:  alu_op = ALU_XOR;
          default:  legal  = 1'b0;
        endcase
      `OP_SHIFT:
        case (func)
          `FN_SLL:  alu_op = ALU_SLL;
          `FN_SRL:  alu_op = ALU_SRL;
          default:  legal  = 1'b0;
        endcase
      default: legal = 1'b0; // Halt lands here too
    endcase
  end

  // Instruction one ahead wins over the register file
  assign opa   = (issue.wr && issue.dest == ra) ? issue.alu_value : rd_a_data;
  assign fwd_b = (issue.wr && issue.dest == rb) ? issue.alu_value : rd_b_data;
  assign opb   = use_lit ? word_t'(dec_ir[20:13]) : fwd_b; // Zero-extended literal

  //////////////////////////////////////////////////
  // Issue register

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      issue.valid <= 1'b0;
      issue.wr    <= 1'b0;
      issue.halt  <= 1'b0;
    end
    else
    begin
      issue.valid <= dec_valid;
      issue.wr    <= dec_valid && legal && (rc != `ZERO_REG);
      issue.halt  <= dec_valid && is_halt;
    end
  end

  always_ff @(posedge clock)
  begin
    issue.ir     <= dec_ir;
    issue.alu_op <= alu_op;
    issue.opa    <= opa;
    issue.opb    <= opb;
    issue.dest   <= rc;
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage import pipe_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  issue_if.execute issue,
  result_if.source result
);

  word_t      alu_out;
  logic [5:0] shamt;

  assign shamt = issue.opb[5:0]; // Low 6 bits only

  //////////////////////////////////////////////////
  // ALU

  always_comb
  begin
    case (issue.alu_op)
      ALU_ADD:    alu_out = issue.opa + issue.opb;
      ALU_SUB:    alu_out = issue.opa - issue.opb;
      ALU_CMPEQ:  alu_out = word_t'(issue.opa == issue.opb);
      ALU_CMPULT: alu_out = word_t'(issue.opa < issue.opb);
      ALU_AND:    alu_out = issue.opa & issue.opb;
      ALU_BIS:    alu_out = issue.opa | issue.opb;
      ALU_XOR:    alu_out = issue.opa ^ issue.opb;
      ALU_SLL:    alu_out = issue.opa << shamt;
      ALU_SRL:    alu_out = issue.opa >> shamt;
      default:    alu_out = '0;
    endcase
  end

  // Back to decode for forwarding
  assign issue.alu_value = alu_out;

  //////////////////////////////////////////////////
  // Result register

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      result.valid <= 1'b0;
      result.wr    <= 1'b0;
      result.halt  <= 1'b0;
    end
    else
    begin
      result.valid <= issue.valid;
      result.wr    <= issue.wr;
      result.halt  <= issue.halt;
    end
  end

  always_ff @(posedge clock)
  begin
    result.ir    <= issue.ir;
    result.dest  <= issue.dest;
    result.value <= alu_out;
  end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

`include "pipe_params.svh"

module reg_file import pipe_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  input  reg_idx_t rd_a_idx,
  input  reg_idx_t rd_b_idx,
  output word_t    rd_a_data,
  output word_t    rd_b_data,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data
);

  word_t regs [`REG_COUNT];

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_idx != `ZERO_REG)
      regs[wr_idx] <= wr_data;
  end

  // Zero register first, then write-through
  assign rd_a_data = (rd_a_idx == `ZERO_REG)             ? '0      :
                     (wr_en && wr_idx == rd_a_idx)        ? wr_data : regs[rd_a_idx];
  assign rd_b_data = (rd_b_idx == `ZERO_REG)             ? '0      :
                     (wr_en && wr_idx == rd_b_idx)        ? wr_data : regs[rd_b_idx];

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`default_nettype none

`include "pipe_params.svh"

module result_stage import pipe_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  result_if.sink   result,
  output logic     commit_valid,
  output inst_t    commit_ir,
  output logic     commit_wr_en,
  output reg_idx_t commit_wr_idx,
  output word_t    commit_wr_data,
  output count_t   completed_count,
  output status_t  error_status
);

  //////////////////////////////////////////////////
  // Commit ports, straight from the result register

  assign commit_valid   = result.valid;
  assign commit_ir      = result.ir;
  assign commit_wr_en   = result.valid && result.wr; // Also the regfile write
  assign commit_wr_idx  = result.dest;
  assign commit_wr_data = result.value;

  // Illegal words and the halt count as well
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      completed_count <= '0;
      error_status    <= `STATUS_NO_ERROR;
    end
    else if (result.valid)
    begin
      completed_count <= completed_count + 1'b1;
      if (result.halt)
        error_status <= `STATUS_HALTED; // Sticky
    end
  end

endmodule

`default_nettype wire

/* logic/pipe_top.sv */
`default_nettype none

module pipe_top import pipe_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  input  logic     inst_valid,
  input  inst_t    inst,
  output logic     inst_ready,
  output logic     commit_valid,
  output inst_t    commit_ir,
  output logic     commit_wr_en,
  output reg_idx_t commit_wr_idx,
  output word_t    commit_wr_data,
  output count_t   completed_count,
  output status_t  error_status
);

  reg_idx_t rd_a_idx;
  reg_idx_t rd_b_idx;
  word_t    rd_a_data;
  word_t    rd_b_data;

  issue_if  issue ();
  result_if result ();

  decode_stage u_decode (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .inst_ready (inst_ready),
    .rd_a_idx   (rd_a_idx),
    .rd_b_idx   (rd_b_idx),
    .rd_a_data  (rd_a_data),
    .rd_b_data  (rd_b_data),
    .issue      (issue.decode)
  );

  execute_stage u_execute (
    .clock  (clock),
    .arst_n (arst_n),
    .issue  (issue.execute),
    .result (result.source)
  );

  // Written by the committing instruction
  reg_file u_reg_file (
    .clock     (clock),
    .arst_n    (arst_n),
    .rd_a_idx  (rd_a_idx),
    .rd_b_idx  (rd_b_idx),
    .rd_a_data (rd_a_data),
    .rd_b_data (rd_b_data),
    .wr_en     (commit_wr_en),
    .wr_idx    (commit_wr_idx),
    .wr_data   (commit_wr_data)
  );

  result_stage u_result (
    .clock           (clock),
    .arst_n          (arst_n),
    .result          (result.sink),
    .commit_valid    (commit_valid),
    .commit_ir       (commit_ir),
    .commit_wr_en    (commit_wr_en),
    .commit_wr_idx   (commit_wr_idx),
    .commit_wr_data  (commit_wr_data),
    .completed_count (completed_count),
    .error_status    (error_status)
  );

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`default_nettype none

module clock_gen #(
  parameter int RESET_CYCLES = 10
)
(
  output logic clock,
  output logic arst_n
);

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock; // Period of 4
  end

  // Released on a falling edge, away from the flops
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/pipe_tb.sv */
`default_nettype none

`include "pipe_params.svh"

module pipe_tb import pipe_pkg::*;
();

  localparam int NUM_TESTS      = 32;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * NUM_TESTS + 20;

  logic     clock;
  logic     arst_n;
  logic     inst_valid;
  inst_t    inst;
  logic     inst_ready;
  logic     commit_valid;
  inst_t    commit_ir;
  logic     commit_wr_en;
  reg_idx_t commit_wr_idx;
  word_t    commit_wr_data;
  count_t   completed_count;
  status_t  error_status;

  // Stimulus table with expected commit values
  string    test_name  [NUM_TESTS];
  inst_t    test_inst  [NUM_TESTS];
  logic     test_wr    [NUM_TESTS];
  reg_idx_t test_idx   [NUM_TESTS];
  word_t    test_data  [NUM_TESTS];
  logic     test_tight [NUM_TESTS]; // No gap before this entry

  int          fill_idx    = 0;
  int          commit_idx  = 0;
  int          cycle_count = 0;
  int          accept_q [$];        // Accepting edge of each instruction in flight
  logic        halt_seen   = 1'b0;
  int unsigned rand_state  = 17;
  int          gap;

  clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clock  (clock),
    .arst_n (arst_n)
  );

  pipe_top UUT (
    .clock           (clock),
    .arst_n          (arst_n),
    .inst_valid      (inst_valid),
    .inst            (inst),
    .inst_ready      (inst_ready),
    .commit_valid    (commit_valid),
    .commit_ir       (commit_ir),
    .commit_wr_en    (commit_wr_en),
    .commit_wr_idx   (commit_wr_idx),
    .commit_wr_data  (commit_wr_data),
    .completed_count (completed_count),
    .error_status    (error_status)
  );

  //////////////////////////////////////////////////
  // Helpers

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Operate format with operand B from register rb
  function automatic inst_t op_reg(input logic [5:0] op, input logic [6:0] fn,
                                   input reg_idx_t ra, input reg_idx_t rb, input reg_idx_t rc);
    return {op, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  // Operate format with operand B from the 8-bit literal
  function automatic inst_t op_lit(input logic [5:0] op, input logic [6:0] fn,
                                   input reg_idx_t ra, input logic [7:0] lit, input reg_idx_t rc);
    return {op, ra, lit, 1'b1, fn, rc};
  endfunction

  task automatic end_with_failure();
    $display("sim failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_error(input string reason);
    $display("%s", reason);
    end_with_failure();
  endtask

  task automatic compare(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %h actual %h", what, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic add_test(input string name, input inst_t word, input int wr, input int idx,
                          input word_t data, input int tight);
    test_name[fill_idx]  = name;
    test_inst[fill_idx]  = word;
    test_wr[fill_idx]    = (wr != 0);
    test_idx[fill_idx]   = reg_idx_t'(idx);
    test_data[fill_idx]  = data;
    test_tight[fill_idx] = (tight != 0);
    fill_idx++;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table

  // Each row gives name, instruction, expected wr_en, wr_idx, wr_data and the no-gap flag
  task automatic load_tests();
    add_test("bis_r1", op_lit(`OP_INTL, `FN_BIS, 31, 100, 1), 1, 1, 64'd100, 0);
    add_test("bis_r2", op_lit(`OP_INTL, `FN_BIS, 31, 7, 2), 1, 2, 64'd7, 1);
    add_test("addq_reg", op_reg(`OP_INTA, `FN_ADDQ, 1, 2, 3), 1, 3, 64'd107, 1);
    add_test("subq_lit", op_lit(`OP_INTA, `FN_SUBQ, 3, 10, 4), 1, 4, 64'd97, 0);
    add_test("subq_neg", op_reg(`OP_INTA, `FN_SUBQ, 2, 1, 5), 1, 5, 64'hffffffffffffffa3, 0);
    add_test("cmpeq_lit", op_lit(`OP_INTA, `FN_CMPEQ, 3, 107, 6), 1, 6, 64'd1, 0);
    add_test("cmpeq_reg", op_reg(`OP_INTA, `FN_CMPEQ, 1, 2, 7), 1, 7, 64'd0, 0);
    add_test("cmpult_reg", op_reg(`OP_INTA, `FN_CMPULT, 2, 1, 8), 1, 8, 64'd1, 0);
    add_test("cmpult_big", op_reg(`OP_INTA, `FN_CMPULT, 5, 1, 9), 1, 9, 64'd0, 0);
    add_test("cmpult_lit", op_lit(`OP_INTA, `FN_CMPULT, 1, 200, 10), 1, 10, 64'd1, 0);
    add_test("and_reg", op_reg(`OP_INTL, `FN_AND, 1, 2, 11), 1, 11, 64'd4, 0);
    add_test("and_lit", op_lit(`OP_INTL, `FN_AND, 5, 8'hf0, 12), 1, 12, 64'ha0, 0);
    add_test("bis_reg", op_reg(`OP_INTL, `FN_BIS, 1, 2, 13), 1, 13, 64'd103, 0);
    add_test("xor_reg", op_reg(`OP_INTL, `FN_XOR, 1, 2, 14), 1, 14, 64'd99, 0);
    add_test("xor_lit", op_lit(`OP_INTL, `FN_XOR, 5, 255, 15), 1, 15, 64'hffffffffffffff5c, 0);
    add_test("sll_lit", op_lit(`OP_SHIFT, `FN_SLL, 1, 4, 16), 1, 16, 64'd1600, 0);
    add_test("sll_reg", op_reg(`OP_SHIFT, `FN_SLL, 2, 2, 17), 1, 17, 64'd896, 0);
    add_test("srl_lit", op_lit(`OP_SHIFT, `FN_SRL, 5, 60, 18), 1, 18, 64'hf, 0);
    add_test("srl_reg", op_reg(`OP_SHIFT, `FN_SRL, 16, 2, 19), 1, 19, 64'd12, 0);
    add_test("sll_6bit", op_lit(`OP_SHIFT, `FN_SLL, 2, 65, 20), 1, 20, 64'd14, 0);
    // Zero register as destination and then as source right behind it
    add_test("write_r31", op_reg(`OP_INTA, `FN_ADDQ, 1, 2, 31), 0, 31, 64'd0, 0);
    add_test("read_r31", op_reg(`OP_INTA, `FN_ADDQ, 31, 1, 21), 1, 21, 64'd100, 1);
    add_test("r31_lit", op_lit(`OP_INTA, `FN_ADDQ, 31, 5, 22), 1, 22, 64'd5, 0);
    // Illegal words aimed at r1 and r2
    add_test("bad_func", op_reg(`OP_INTA, 7'h7f, 2, 2, 1), 0, 1, 64'd0, 0);
    add_test("bad_opcode", op_reg(6'h08, `FN_ADDQ, 1, 1, 2), 0, 2, 64'd0, 1);
    add_test("keep_r1", op_lit(`OP_INTA, `FN_ADDQ, 1, 0, 23), 1, 23, 64'd100, 1);
    add_test("keep_r2", op_reg(`OP_INTL, `FN_BIS, 2, 31, 24), 1, 24, 64'd7, 0);
    // Dependent chain
    add_test("chain_0", op_reg(`OP_INTA, `FN_ADDQ, 24, 24, 25), 1, 25, 64'd14, 1);
    add_test("chain_1", op_reg(`OP_INTA, `FN_ADDQ, 25, 25, 26), 1, 26, 64'd28, 1);
    add_test("chain_2", op_reg(`OP_INTA, `FN_SUBQ, 26, 25, 27), 1, 27, 64'd14, 1);
    add_test("chain_3", op_reg(`OP_INTL, `FN_XOR, 27, 26, 28), 1, 28, 64'd18, 1);
    add_test("halt", `HALT_INST, 0, 0, 64'd0, 0);
    if (fill_idx != NUM_TESTS)
      report_error("Stimulus table length does not match NUM_TESTS");
  endtask

  //////////////////////////////////////////////////
  // Commit checker sampled on the falling edge

  task automatic check_commit();
    int accepted_at;
    if (commit_idx >= NUM_TESTS)
      report_error("A commit appeared after the halt had committed");
    if (accept_q.size() == 0)
      report_error("A commit appeared with no instruction accepted");
    accepted_at = accept_q.pop_front();
    compare($sformatf("%s latency", test_name[commit_idx]), accepted_at + 2, cycle_count);
    compare($sformatf("%s ir", test_name[commit_idx]), test_inst[commit_idx], commit_ir);
    compare($sformatf("%s wr_en", test_name[commit_idx]), test_wr[commit_idx], commit_wr_en);
    if (test_wr[commit_idx])
    begin
      compare($sformatf("%s wr_idx", test_name[commit_idx]), test_idx[commit_idx],
              commit_wr_idx);
      compare($sformatf("%s wr_data", test_name[commit_idx]), test_data[commit_idx],
              commit_wr_data);
    end
    commit_idx++;
  endtask

  always @(negedge clock)
  begin
    if (arst_n)
    begin
      if (halt_seen && inst_ready)
        report_error("inst_ready came back after the halt word was accepted");
      if (inst_valid && inst_ready)
      begin
        accept_q.push_back(cycle_count + 1); // Taken on the coming edge
        if (inst == `HALT_INST)
          halt_seen = 1'b1;
      end
      if (commit_valid)
        check_commit();
    end
  end

  always @(posedge clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      report_error($sformatf("Timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES));
  end

  //////////////////////////////////////////////////
  // Driver

  initial
  begin
    inst_valid = 1'b0;
    inst       = '0;
    load_tests();
    wait (arst_n === 1'b1);
    @(negedge clock);
    compare("reset commit_valid", 1'b0, commit_valid);
    compare("reset completed_count", 0, completed_count);
    compare("reset error_status", `STATUS_NO_ERROR, error_status);
    compare("reset inst_ready", 1'b1, inst_ready);

    for (int i = 0; i < NUM_TESTS; i++)
    begin
      rand_state = lcg_next(rand_state);
      gap        = test_tight[i] ? 0 : int'((rand_state >> 16) % 4);
      repeat (gap)
      begin
        @(posedge clock);
        inst_valid <= 1'b0;
      end
      @(posedge clock);
      inst_valid <= 1'b1;
      inst       <= test_inst[i];
      @(negedge clock);
      while (!inst_ready)
        @(negedge clock);
    end
    @(posedge clock);
    inst_valid <= 1'b0; // Halt taken on this edge

    wait (commit_idx == NUM_TESTS);
    @(negedge clock);
    compare("halt error_status", `STATUS_HALTED, error_status);
    compare("halt completed_count", NUM_TESTS, completed_count);
    repeat (4) @(negedge clock);
    if (!inst_ready && !commit_valid)
    begin
      $display("sim passed");
      $finish;
    end
    else
      report_error("Pipeline was still active after the halt committed");
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
logic/pipe_pkg.sv
logic/issue_if.sv
logic/result_if.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/reg_file.sv
logic/result_stage.sv
logic/pipe_top.sv
test/clock_gen.sv
test/pipe_tb.sv

/* Bender.yml */
package:
  name: pipe_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/pipe_pkg.sv
      - logic/issue_if.sv
      - logic/result_if.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/reg_file.sv
      - logic/result_stage.sv
      - logic/pipe_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/clock_gen.sv
      - test/pipe_tb.sv
